//--- logic/ls_pkg.sv
`default_nettype none

package ls_pkg;

    //////////////////////////////////////////////////
    // Widths and memory geometry
    localparam int XLEN = 32;
    localparam int MEM_WORDS = 256;
    // Word index comes from byte address bits 9:2
    localparam int MEM_ADDR_W = 8;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [3:0] byte_en_t;

    //////////////////////////////////////////////////
    // Instruction encodings
    localparam logic [6:0] OPCODE_LOAD = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        LS_B = 3'b000,
        LS_H = 3'b001,
        LS_W = 3'b010,
        L_BU = 3'b100,
        L_HU = 3'b101
    } ls_fn3_t;

    // Exception causes, numbered as in mcause
    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_ILLEGAL_INST = 4'd2,
        EXC_LOAD_MISALIGNED = 4'd4,
        EXC_STORE_MISALIGNED = 4'd6
    } exc_code_t;

    // One instruction word seen as I-type (loads) or S-type (stores)
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0] rs1;
            logic [2:0] fn3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } i_form;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] fn3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_form;
    } ls_instr_u;

endpackage

`default_nettype wire

//--- logic/mem_sub_unit_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_sub_unit_if import ls_pkg::*; ();

    // Request side, one-cycle pulse on new_request
    logic new_request;
    word_t addr;
    logic re;
    logic we;
    byte_en_t be;
    word_t data_in;

    // Response side, exactly one cycle after the request
    word_t data_out;
    logic data_valid;

    modport controller (
        output new_request, addr, re, we, be, data_in
    );

    modport responder (
        input new_request, addr, re, we, be, data_in,
        output data_out, data_valid
    );

    modport monitor (
        input data_valid, data_out
    );

endinterface

`default_nettype wire

//--- logic/ls_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ls_issue import ls_pkg::*; (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input ls_instr_u instr,
    input word_t rs1_data,
    input word_t rs2_data,
    mem_sub_unit_if.controller mem,
    output ls_fn3_t load_fn3,
    output logic [1:0] byte_addr,
    output logic fault_pulse,
    output logic exc_set,
    output exc_code_t exc_code_in,
    output word_t exc_tval_in
);

    logic busy;
    logic accept;
    logic is_load;
    logic is_store;
    logic fn3_ok;
    logic illegal;
    logic misaligned;
    logic fault;
    ls_fn3_t fn3;
    logic [11:0] offset;
    word_t addr;
    byte_en_t be;
    word_t store_data;

    //////////////////////////////////////////////////
    // Decode and address
    always_comb begin
        fn3 = ls_fn3_t'(instr.i_form.fn3);
        is_load = instr.i_form.opcode == OPCODE_LOAD;
        is_store = instr.s_form.opcode == OPCODE_STORE;
        case (fn3)
            LS_B, LS_H, LS_W: fn3_ok = 1'b1;
            L_BU, L_HU: fn3_ok = is_load;
            default: fn3_ok = 1'b0;
        endcase
        illegal = ~(is_load | is_store) | ~fn3_ok;

        offset = is_store ? {instr.s_form.imm_hi, instr.s_form.imm_lo} : instr.i_form.imm;
        addr = rs1_data + {{(XLEN-12){offset[11]}}, offset};

        case (fn3)
            LS_H, L_HU: misaligned = addr[0];
            LS_W: misaligned = |addr[1:0];
            default: misaligned = 1'b0;
        endcase
        fault = illegal | misaligned;
    end

    // Byte lanes for stores
    always_comb begin
        case (fn3)
            LS_B: be = byte_en_t'(4'b0001 << addr[1:0]);
            LS_H: be = byte_en_t'(4'b0011 << addr[1:0]);
            default: be = 4'b1111;
        endcase
        store_data = rs2_data << {addr[1:0], 3'b000};
    end

    assign accept = req & ~busy;

    // Exception capture happens on the accepting edge
    assign exc_set = accept & fault;
    assign exc_code_in = illegal ? EXC_ILLEGAL_INST :
                         is_load ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
    assign exc_tval_in = illegal ? word_t'(instr) : addr;

    //////////////////////////////////////////////////
    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            mem.new_request <= 1'b0;
            fault_pulse <= 1'b0;
        end else begin
            mem.new_request <= accept & ~fault;
            fault_pulse <= accept & fault;
            if (accept)
                busy <= 1'b1;
            else if (~req & ~ack)
                busy <= 1'b0;
        end
    end

    // Request payload and load attributes
    always_ff @(posedge clk) begin
        if (accept) begin
            mem.addr <= addr;
            mem.re <= is_load;
            mem.we <= is_store;
            mem.be <= is_store ? be : '0;
            mem.data_in <= store_data;
            load_fn3 <= fn3;
            byte_addr <= addr[1:0];
        end
    end

endmodule

`default_nettype wire

//--- logic/ls_exception_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ls_exception_regs import ls_pkg::*; (
    input logic clk,
    input logic rst,
    input logic exc_set,
    input exc_code_t exc_code_in,
    input word_t exc_tval_in,
    input logic exc_clear,
    output logic exc_valid,
    output exc_code_t exc_code,
    output word_t exc_tval
);

    logic capture;

    // First exception wins until cleared
    assign capture = exc_set & ~exc_valid & ~exc_clear;

    //////////////////////////////////////////////////
    // Sticky cause
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
            exc_code <= EXC_NONE;
        end else if (exc_clear) begin
            exc_valid <= 1'b0;
            exc_code <= EXC_NONE;
        end else if (capture) begin
            exc_valid <= 1'b1;
            exc_code <= exc_code_in;
        end
    end

    // Faulting address or instruction word
    always_ff @(posedge clk) begin
        if (capture)
            exc_tval <= exc_tval_in;
    end

endmodule

`default_nettype wire

//--- logic/local_mem_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module local_mem_sub_unit import ls_pkg::*; (
    input logic clk,
    input logic rst,
    mem_sub_unit_if.responder mem
);

    word_t ram [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] word_idx;

    // Upper address bits are dropped, so accesses wrap
    assign word_idx = mem.addr[MEM_ADDR_W+1:2];

    //////////////////////////////////////////////////
    // Storage with byte-enable writes
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++)
                ram[i] <= '0;
        end else if (mem.new_request & mem.we) begin
            for (int b = 0; b < 4; b++) begin
                if (mem.be[b])
                    ram[word_idx][b*8 +: 8] <= mem.data_in[b*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Response
    always_ff @(posedge clk) begin
        if (rst)
            mem.data_valid <= 1'b0;
        else
            mem.data_valid <= mem.new_request;
    end

    // Old word on a read, zero for a store
    always_ff @(posedge clk) begin
        if (mem.new_request)
            mem.data_out <= mem.re ? ram[word_idx] : '0;
    end

endmodule

`default_nettype wire

//--- logic/ls_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module ls_writeback import ls_pkg::*; (
    input logic clk,
    input logic rst,
    input logic req,
    mem_sub_unit_if.monitor mem,
    input ls_fn3_t load_fn3,
    input logic [1:0] byte_addr,
    input logic fault_pulse,
    output logic ack,
    output word_t load_data,
    output logic fault
);

    logic [7:0] sel_byte;
    logic [15:0] sel_half;
    word_t extended;

    //////////////////////////////////////////////////
    // Lane select and extension
    always_comb begin
        sel_byte = mem.data_out[{byte_addr, 3'b000} +: 8];
        sel_half = byte_addr[1] ? mem.data_out[31:16] : mem.data_out[15:0];
        case (load_fn3)
            LS_B: extended = {{24{sel_byte[7]}}, sel_byte};
            L_BU: extended = {24'b0, sel_byte};
            LS_H: extended = {{16{sel_half[15]}}, sel_half};
            L_HU: extended = {16'b0, sel_half};
            default: extended = mem.data_out;
        endcase
    end

    //////////////////////////////////////////////////
    // Handshake back to the source
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
            fault <= 1'b0;
        end else if (mem.data_valid) begin
            ack <= 1'b1;
            fault <= 1'b0;
        end else if (fault_pulse) begin
            ack <= 1'b1;
            fault <= 1'b1;
        end else if (~req) begin
            ack <= 1'b0;
            fault <= 1'b0;
        end
    end

    // Result held until the next response
    always_ff @(posedge clk) begin
        if (mem.data_valid)
            load_data <= extended;
        else if (fault_pulse)
            load_data <= '0;
    end

endmodule

`default_nettype wire

//--- logic/load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import ls_pkg::*; (
    input logic clk,
    input logic rst,

    // Four-phase request
    input logic req,
    input word_t instr,
    input word_t rs1_data,
    input word_t rs2_data,
    output logic ack,
    output word_t load_data,
    output logic fault,

    // Exception status
    input logic exc_clear,
    output logic exc_valid,
    output exc_code_t exc_code,
    output word_t exc_tval
);

    mem_sub_unit_if mem_bus ();

    ls_fn3_t load_fn3;
    logic [1:0] byte_addr;
    logic fault_pulse;
    logic exc_set;
    exc_code_t exc_code_in;
    word_t exc_tval_in;

    //////////////////////////////////////////////////
    // Issue and exceptions
    ls_issue issue_inst (
        .clk (clk),
        .rst (rst),
        .req (req),
        .ack (ack),
        .instr (instr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .mem (mem_bus.controller),
        .load_fn3 (load_fn3),
        .byte_addr (byte_addr),
        .fault_pulse (fault_pulse),
        .exc_set (exc_set),
        .exc_code_in (exc_code_in),
        .exc_tval_in (exc_tval_in)
    );

    ls_exception_regs exc_regs_inst (
        .clk (clk),
        .rst (rst),
        .exc_set (exc_set),
        .exc_code_in (exc_code_in),
        .exc_tval_in (exc_tval_in),
        .exc_clear (exc_clear),
        .exc_valid (exc_valid),
        .exc_code (exc_code),
        .exc_tval (exc_tval)
    );

    //////////////////////////////////////////////////
    // Memory and writeback
    local_mem_sub_unit local_mem_inst (
        .clk (clk),
        .rst (rst),
        .mem (mem_bus.responder)
    );

    ls_writeback writeback_inst (
        .clk (clk),
        .rst (rst),
        .req (req),
        .mem (mem_bus.monitor),
        .load_fn3 (load_fn3),
        .byte_addr (byte_addr),
        .fault_pulse (fault_pulse),
        .ack (ack),
        .load_data (load_data),
        .fault (fault)
    );

endmodule

`default_nettype wire

//--- test/ls_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module ls_clock_gen (
    output logic clk
);

    // 8 ns period
    localparam int HALF_PERIOD_NS = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/load_store_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_assertions import ls_pkg::*; (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input word_t load_data,
    input logic fault
);

    // Failed property count
    int fail_count = 0;

    //////////////////////////////////////////////////
    // Four-phase handshake
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
    else begin
        fail_count++;
        $error("ack rose while req was low");
    end

    ack_fall_needs_no_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
    else begin
        fail_count++;
        $error("ack fell while req was still high");
    end

    // Response held for as long as ack stays high
    outputs_stable: assert property (@(posedge clk) disable iff (rst)
        ack && $past(ack) |-> $stable(load_data) && $stable(fault))
    else begin
        fail_count++;
        $error("load_data or fault changed while ack was high");
    end

endmodule

`default_nettype wire

//--- test/load_store_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_tb import ls_pkg::*; ();

    localparam int NUM_TXNS = 400;
    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES = 5;
    localparam int ACK_WAIT_CYCLES = 16;
    localparam int WATCHDOG_NS = NUM_TXNS * 20 * CLK_PERIOD_NS;

    logic clk;
    logic rst;
    logic req;
    logic exc_clear;
    word_t instr;
    word_t rs1_data;
    word_t rs2_data;
    logic ack;
    word_t load_data;
    logic fault;
    logic exc_valid;
    exc_code_t exc_code;
    word_t exc_tval;

    integer seed;
    word_t mem_model [MEM_WORDS];
    logic exc_valid_m;
    exc_code_t exc_code_m;
    word_t exc_tval_m;

    ls_clock_gen clock_gen_inst (.clk(clk));

    load_store_unit load_store_unit_inst (.*);

    bind load_store_unit load_store_unit_assertions assertions_inst (.*);

    //////////////////////////////////////////////////
    // Reporting and compare tasks
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    // Valid follows from a code other than EXC_NONE; tval counts only while valid
    task automatic check_exc(input string name, input exc_code_t exp_code, input word_t exp_tval);
        if (exc_valid !== (exp_code != EXC_NONE) || exc_code !== exp_code)
            report_failure($sformatf("mismatch %s expected exc %s actual %s (valid %b)",
                                     name, exp_code.name(), exc_code.name(), exc_valid));
        else if (exp_code != EXC_NONE && exc_tval !== exp_tval)
            report_failure($sformatf("mismatch %s expected tval %08h actual %08h",
                                     name, exp_tval, exc_tval));
    endtask

    //////////////////////////////////////////////////
    // Reference model of one request
    task automatic predict(input word_t ins, input word_t rs1, input word_t rs2,
                           output logic exp_fault, output word_t exp_data);
        logic [2:0] fn3;
        logic [11:0] off;
        logic ld;
        logic st;
        word_t addr;
        word_t word;
        exc_code_t code;
        int k;
        fn3 = ins[14:12];
        ld = ins[6:0] == OPCODE_LOAD && fn3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        st = ins[6:0] == OPCODE_STORE && fn3 inside {3'd0, 3'd1, 3'd2};
        off = st ? {ins[31:25], ins[11:7]} : ins[31:20];
        addr = rs1 + {{20{off[11]}}, off};
        word = mem_model[addr[9:2]] >> {addr[1:0], 3'b000};
        exp_data = '0;
        exp_fault = 1'b1;
        if (!ld && !st)
            code = EXC_ILLEGAL_INST;
        else if ((fn3[1:0] == 2'd1 && addr[0]) || (fn3[1:0] == 2'd2 && addr[1:0] != 2'd0))
            code = ld ? EXC_LOAD_MISALIGNED : EXC_STORE_MISALIGNED;
        else begin
            exp_fault = 1'b0;
            code = EXC_NONE;
            if (ld) begin
                case (fn3)
                    3'd0: exp_data = {{24{word[7]}}, word[7:0]};
                    3'd1: exp_data = {{16{word[15]}}, word[15:0]};
                    3'd4: exp_data = {24'b0, word[7:0]};
                    3'd5: exp_data = {16'b0, word[15:0]};
                    default: exp_data = mem_model[addr[9:2]];
                endcase
            end else begin
                // Byte b of the word takes byte k of rs2
                for (int b = 0; b < 4; b++) begin
                    k = b - int'(addr[1:0]);
                    if (k >= 0 && k < (1 << fn3[1:0]))
                        mem_model[addr[9:2]][8*b +: 8] = rs2[8*k +: 8];
                end
            end
        end
        if (exp_fault && !exc_valid_m) begin
            exc_valid_m = 1'b1;
            exc_code_m = code;
            exc_tval_m = (code == EXC_ILLEGAL_INST) ? ins : addr;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    task automatic make_txn(output word_t ins, output word_t rs1, output word_t rs2);
        word_t r;
        word_t f;
        word_t addr;
        logic [3:0] kind;
        logic [2:0] fn3;
        logic [11:0] off;
        logic is_st;
        r = $random(seed);
        f = $random(seed);
        addr = $random(seed);
        rs2 = $random(seed);
        kind = r[3:0];
        off = r[31:20];
        is_st = 1'b0;
        // Half the accesses go to 16 words so loads find stored data
        if (r[4])
            addr[9:6] = 4'b0;
        if (kind < 4'd6) begin
            is_st = 1'b1;
            fn3 = {1'b0, r[6:5]};
            if (fn3 == 3'd3)
                fn3 = 3'd2;
        end else if (kind < 4'd12) begin
            fn3 = {r[7], r[6:5]};
            if (fn3[1:0] == 2'd3)
                fn3 = 3'd2;
        end else if (kind < 4'd14) begin
            is_st = r[9];
            fn3 = r[7] ? 3'd2 : {~r[9] & r[8], 2'b01};
        end else if (kind == 4'd14) begin
            is_st = 1'b1;
            fn3 = {1'b1, r[6:5]};
        end else
            fn3 = {r[6], 2'b11};
        if (kind < 4'd12) begin
            if (fn3[1:0] == 2'd1)
                addr[0] = 1'b0;
            if (fn3[1:0] == 2'd2)
                addr[1:0] = 2'b00;
        end else if (kind < 4'd14) begin
            if (fn3[1:0] == 2'd1)
                addr[0] = 1'b1;
            else if (addr[1:0] == 2'b00)
                addr[1:0] = 2'b10;
        end
        rs1 = addr - {{20{off[11]}}, off};
        if (is_st)
            ins = {off[11:5], f[24:20], f[19:15], fn3, off[4:0], OPCODE_STORE};
        else
            ins = {off, f[19:15], fn3, f[11:7], OPCODE_LOAD};
        if (kind == 4'd15 && r[5])
            ins = {f[31:7], 7'b0001111};
    endtask

    task automatic wait_ack(input logic level, input string name);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            if (cycles == ACK_WAIT_CYCLES)
                report_failure($sformatf("%s: ack did not go to %b within %0d cycles",
                                         name, level, ACK_WAIT_CYCLES));
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // Full four-phase handshake for one request
    task automatic run_txn(input int n);
        word_t ins;
        word_t a;
        word_t b;
        word_t exp_data;
        logic exp_fault;
        string name;
        make_txn(ins, a, b);
        predict(ins, a, b, exp_fault, exp_data);
        name = $sformatf("txn %0d instr %08h", n, ins);
        instr = ins;
        rs1_data = a;
        rs2_data = b;
        req = 1'b1;
        wait_ack(1'b1, name);
        check_word({name, " load_data"}, exp_data, load_data);
        check_fault({name, " fault"}, exp_fault, fault);
        check_exc(name, exc_code_m, exc_tval_m);
        req = 1'b0;
        wait_ack(1'b0, name);
    endtask

    // At least one idle edge so the issue logic leaves its busy state
    task automatic idle_gap();
        word_t r;
        r = $random(seed);
        @(posedge clk);
        #1;
        if (r[2:0] == 3'd0) begin
            exc_clear = 1'b1;
            @(posedge clk);
            #1;
            exc_clear = 1'b0;
            exc_valid_m = 1'b0;
            exc_code_m = EXC_NONE;
            check_exc("exc_clear", EXC_NONE, '0);
        end
        repeat (r[4:3]) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("Run timed out before all transactions finished");
    end

    // Watch the bound handshake assertions
    initial begin
        wait (load_store_unit_inst.assertions_inst.fail_count != 0);
        report_failure("Handshake assertion failed during the run");
    end

    initial begin
        seed = 11241;
        rst = 1'b1;
        req = 1'b0;
        exc_clear = 1'b0;
        instr = '0;
        rs1_data = '0;
        rs2_data = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem_model[i] = '0;
        exc_valid_m = 1'b0;
        exc_code_m = EXC_NONE;
        exc_tval_m = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        check_fault("reset ack", 1'b0, ack);
        check_fault("reset fault", 1'b0, fault);
        check_exc("reset", EXC_NONE, '0);
        for (int n = 0; n < NUM_TXNS; n++) begin
            run_txn(n);
            idle_gap();
        end
        if (load_store_unit_inst.assertions_inst.fail_count != 0)
            report_failure("Handshake assertions failed during the run");
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/ls_pkg.sv
logic/mem_sub_unit_if.sv
logic/ls_issue.sv
logic/ls_exception_regs.sv
logic/local_mem_sub_unit.sv
logic/ls_writeback.sv
logic/load_store_unit.sv
test/ls_clock_gen.sv
test/load_store_unit_assertions.sv
test/load_store_unit_tb.sv

//--- Makefile
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP ?= load_store_unit_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | \
		awk '{ print } index($$0, "$(PASS_MSG)") { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
